//--- hdl/soc_bus_pkg.sv
package soc_bus_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // Base RAM window, 4 MiB
    localparam logic [ADDR_W-1:0] BASERAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] BASERAM_MASK = 32'hFFC0_0000;

    // Ext RAM window, right above Base RAM
    localparam logic [ADDR_W-1:0] EXTRAM_BASE  = 32'h8040_0000;
    localparam logic [ADDR_W-1:0] EXTRAM_MASK  = 32'hFFC0_0000;

    // CLINT window, 1 MiB
    localparam logic [ADDR_W-1:0] CLINT_BASE   = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_MASK   = 32'hFFF0_0000;

    // CLINT register offsets inside the window
    localparam logic [15:0] MTIMECMP_LO_OFS = 16'h4000;
    localparam logic [15:0] MTIMECMP_HI_OFS = 16'h4004;
    localparam logic [15:0] MTIME_LO_OFS    = 16'hBFF8;
    localparam logic [15:0] MTIME_HI_OFS    = 16'hBFFC;

    // Timer width
    localparam int MTIME_W = 64;

    // Default on-chip RAM depth in words
    localparam int RAM_WORDS_DEFAULT = 1024;

    // Current bus owner
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_DATA,
        GRANT_INST
    } grant_e;

    // Slave picked by the address decode
    typedef enum logic [1:0] {
        SEL_BASE,
        SEL_EXT,
        SEL_CLINT,
        SEL_NONE
    } slave_sel_e;

endpackage

//--- hdl/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                            sys_clk_i,
    input  logic                            sys_rst_i,
    // Data master
    input  logic                            data_cyc_i,
    input  logic                            data_stb_i,
    input  logic                            data_we_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]   data_sel_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]  data_adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  data_dat_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  data_dat_o,
    output logic                            data_ack_o,
    output logic                            data_err_o,
    // Instruction master
    input  logic                            inst_cyc_i,
    input  logic                            inst_stb_i,
    input  logic                            inst_we_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]   inst_sel_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]  inst_adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  inst_dat_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  inst_dat_o,
    output logic                            inst_ack_o,
    output logic                            inst_err_o,
    // Merged bus towards the decoder
    output logic                            bus_cyc_o,
    output logic                            bus_stb_o,
    output logic                            bus_we_o,
    output logic [soc_bus_pkg::SEL_W-1:0]   bus_sel_o,
    output logic [soc_bus_pkg::ADDR_W-1:0]  bus_adr_o,
    output logic [soc_bus_pkg::DATA_W-1:0]  bus_dat_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]  bus_dat_i,
    input  logic                            bus_ack_i,
    input  logic                            bus_err_i
);
    import soc_bus_pkg::*;

    grant_e grant_q;
    logic   data_req;
    logic   inst_req;

    assign data_req = data_cyc_i & data_stb_i;
    assign inst_req = inst_cyc_i & inst_stb_i;

    // Grant taken only from idle, data master first
    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            grant_q <= GRANT_NONE;
        end else begin
            case (grant_q)
                GRANT_NONE: begin
                    if (data_req) begin
                        grant_q <= GRANT_DATA;
                    end else if (inst_req) begin
                        grant_q <= GRANT_INST;
                    end
                end
                // Owner keeps the bus until its cyc drops
                GRANT_DATA: begin
                    if (!data_cyc_i) begin
                        grant_q <= GRANT_NONE;
                    end
                end
                GRANT_INST: begin
                    if (!inst_cyc_i) begin
                        grant_q <= GRANT_NONE;
                    end
                end
                default: grant_q <= GRANT_NONE;
            endcase
        end
    end

    // Request mux, bus stays quiet while idle
    always_comb begin
        bus_cyc_o = 1'b0;
        bus_stb_o = 1'b0;
        bus_we_o  = 1'b0;
        bus_sel_o = '0;
        bus_adr_o = '0;
        bus_dat_o = '0;
        if (grant_q == GRANT_DATA) begin
            bus_cyc_o = data_cyc_i;
            bus_stb_o = data_stb_i;
            bus_we_o  = data_we_i;
            bus_sel_o = data_sel_i;
            bus_adr_o = data_adr_i;
            bus_dat_o = data_dat_i;
        end else if (grant_q == GRANT_INST) begin
            bus_cyc_o = inst_cyc_i;
            bus_stb_o = inst_stb_i;
            bus_we_o  = inst_we_i;
            bus_sel_o = inst_sel_i;
            bus_adr_o = inst_adr_i;
            bus_dat_o = inst_dat_i;
        end
    end

    // Responses go back to the owner only
    assign data_ack_o = (grant_q == GRANT_DATA) & bus_ack_i;
    assign data_err_o = (grant_q == GRANT_DATA) & bus_err_i;
    assign data_dat_o = (grant_q == GRANT_DATA) ? bus_dat_i : '0;
    assign inst_ack_o = (grant_q == GRANT_INST) & bus_ack_i;
    assign inst_err_o = (grant_q == GRANT_INST) & bus_err_i;
    assign inst_dat_o = (grant_q == GRANT_INST) ? bus_dat_i : '0;

endmodule

//--- hdl/wb_decoder.sv
`timescale 1ns/1ps

module wb_decoder (
    input  logic                            sys_clk_i,
    input  logic                            sys_rst_i,
    // Merged bus from the arbiter
    input  logic                            cyc_i,
    input  logic                            stb_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]  adr_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  dat_o,
    output logic                            ack_o,
    output logic                            err_o,
    // Base RAM
    output logic                            base_stb_o,
    input  logic                            base_ack_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  base_dat_i,
    // Ext RAM
    output logic                            ext_stb_o,
    input  logic                            ext_ack_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  ext_dat_i,
    // CLINT
    output logic                            clint_stb_o,
    input  logic                            clint_ack_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  clint_dat_i
);
    import soc_bus_pkg::*;

    slave_sel_e slave_sel;
    logic       req;
    logic       err_q;

    assign req = cyc_i & stb_i;

    // Window match by base and mask
    always_comb begin
        if ((adr_i & BASERAM_MASK) == BASERAM_BASE) begin
            slave_sel = SEL_BASE;
        end else if ((adr_i & EXTRAM_MASK) == EXTRAM_BASE) begin
            slave_sel = SEL_EXT;
        end else if ((adr_i & CLINT_MASK) == CLINT_BASE) begin
            slave_sel = SEL_CLINT;
        end else begin
            slave_sel = SEL_NONE;
        end
    end

    // Strobe reaches the matched slave only
    assign base_stb_o  = req & (slave_sel == SEL_BASE);
    assign ext_stb_o   = req & (slave_sel == SEL_EXT);
    assign clint_stb_o = req & (slave_sel == SEL_CLINT);

    // Unmapped hole, one-cycle err like a slave ack
    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & (slave_sel == SEL_NONE) & ~err_q;
        end
    end

    assign err_o = err_q;

    // Address is held by the master, so slave_sel still points at the responder
    always_comb begin
        case (slave_sel)
            SEL_BASE: begin
                ack_o = base_ack_i;
                dat_o = base_dat_i;
            end
            SEL_EXT: begin
                ack_o = ext_ack_i;
                dat_o = ext_dat_i;
            end
            SEL_CLINT: begin
                ack_o = clint_ack_i;
                dat_o = clint_dat_i;
            end
            default: begin
                ack_o = 1'b0;
                dat_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/wb_ram.sv
`timescale 1ns/1ps

module wb_ram #(
    parameter int RAM_WORDS = soc_bus_pkg::RAM_WORDS_DEFAULT
) (
    input  logic                            sys_clk_i,
    input  logic                            sys_rst_i,
    input  logic                            stb_i,
    input  logic                            we_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]   sel_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]  adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  dat_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  dat_o,
    output logic                            ack_o
);
    import soc_bus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic              accept;

    // Word index, upper bits alias
    assign idx    = adr_i[IDX_W+1:2];
    // No second accept while ack is up
    assign accept = stb_i & ~ack_o;

    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= accept;
        end
    end

    // Storage and read register
    always_ff @(posedge sys_clk_i) begin
        if (accept) begin
            dat_o <= mem[idx];
            if (we_i) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (sel_i[i]) begin
                        mem[idx][8*i +: 8] <= dat_i[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- hdl/clint.sv
`timescale 1ns/1ps

module clint (
    input  logic                            sys_clk_i,
    input  logic                            sys_rst_i,
    input  logic                            stb_i,
    input  logic                            we_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]   sel_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]  adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  dat_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  dat_o,
    output logic                            ack_o,
    output logic                            timer_irq_o,
    output logic [soc_bus_pkg::MTIME_W-1:0] mtime_o
);
    import soc_bus_pkg::*;

    logic [MTIME_W-1:0] mtime_q;
    logic [MTIME_W-1:0] mtimecmp_q;
    logic [15:0]        ofs;
    logic               accept;
    logic [DATA_W-1:0]  rd_val;

    // Decoder already fixed the window, only the offset matters here
    assign ofs    = adr_i[15:0];
    assign accept = stb_i & ~ack_o;

    // Read mux, holes read as zero
    always_comb begin
        case (ofs)
            MTIMECMP_LO_OFS: rd_val = mtimecmp_q[31:0];
            MTIMECMP_HI_OFS: rd_val = mtimecmp_q[63:32];
            MTIME_LO_OFS:    rd_val = mtime_q[31:0];
            MTIME_HI_OFS:    rd_val = mtime_q[63:32];
            default:         rd_val = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            ack_o      <= 1'b0;
        end else begin
            // Free-running, read-only from the bus
            mtime_q <= mtime_q + 64'd1;
            ack_o   <= accept;
            // Compare register, written bytewise in the accept cycle
            if (accept && we_i) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (sel_i[i] && ofs == MTIMECMP_LO_OFS) begin
                        mtimecmp_q[8*i +: 8] <= dat_i[8*i +: 8];
                    end
                    if (sel_i[i] && ofs == MTIMECMP_HI_OFS) begin
                        mtimecmp_q[32+8*i +: 8] <= dat_i[8*i +: 8];
                    end
                end
            end
        end
    end

    // Read data captured alongside the ack
    always_ff @(posedge sys_clk_i) begin
        if (accept) begin
            dat_o <= rd_val;
        end
    end

    // Level interrupt, drops once mtimecmp moves ahead
    assign timer_irq_o = (mtime_q >= mtimecmp_q);
    assign mtime_o     = mtime_q;

endmodule

//--- hdl/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                            sys_clk_i,
    input  logic                            sys_rst_i,
    // Data master
    input  logic                            data_cyc_i,
    input  logic                            data_stb_i,
    input  logic                            data_we_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]   data_sel_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]  data_adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  data_dat_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  data_dat_o,
    output logic                            data_ack_o,
    output logic                            data_err_o,
    // Instruction master
    input  logic                            inst_cyc_i,
    input  logic                            inst_stb_i,
    input  logic                            inst_we_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]   inst_sel_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]  inst_adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]  inst_dat_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  inst_dat_o,
    output logic                            inst_ack_o,
    output logic                            inst_err_o,
    // Timer
    output logic                            timer_irq_o,
    output logic [soc_bus_pkg::MTIME_W-1:0] mtime_o
);
    import soc_bus_pkg::*;

    // Merged bus after arbitration
    logic              bus_cyc;
    logic              bus_stb;
    logic              bus_we;
    logic [SEL_W-1:0]  bus_sel;
    logic [ADDR_W-1:0] bus_adr;
    logic [DATA_W-1:0] bus_wdat;
    logic [DATA_W-1:0] bus_rdat;
    logic              bus_ack;
    logic              bus_err;

    // Per-slave strobe and response
    logic              base_stb;
    logic              base_ack;
    logic [DATA_W-1:0] base_rdat;
    logic              ext_stb;
    logic              ext_ack;
    logic [DATA_W-1:0] ext_rdat;
    logic              clint_stb;
    logic              clint_ack;
    logic [DATA_W-1:0] clint_rdat;

    wb_arbiter u_arbiter (
        .sys_clk_i  (sys_clk_i),
        .sys_rst_i  (sys_rst_i),
        .data_cyc_i (data_cyc_i),
        .data_stb_i (data_stb_i),
        .data_we_i  (data_we_i),
        .data_sel_i (data_sel_i),
        .data_adr_i (data_adr_i),
        .data_dat_i (data_dat_i),
        .data_dat_o (data_dat_o),
        .data_ack_o (data_ack_o),
        .data_err_o (data_err_o),
        .inst_cyc_i (inst_cyc_i),
        .inst_stb_i (inst_stb_i),
        .inst_we_i  (inst_we_i),
        .inst_sel_i (inst_sel_i),
        .inst_adr_i (inst_adr_i),
        .inst_dat_i (inst_dat_i),
        .inst_dat_o (inst_dat_o),
        .inst_ack_o (inst_ack_o),
        .inst_err_o (inst_err_o),
        .bus_cyc_o  (bus_cyc),
        .bus_stb_o  (bus_stb),
        .bus_we_o   (bus_we),
        .bus_sel_o  (bus_sel),
        .bus_adr_o  (bus_adr),
        .bus_dat_o  (bus_wdat),
        .bus_dat_i  (bus_rdat),
        .bus_ack_i  (bus_ack),
        .bus_err_i  (bus_err)
    );

    wb_decoder u_decoder (
        .sys_clk_i   (sys_clk_i),
        .sys_rst_i   (sys_rst_i),
        .cyc_i       (bus_cyc),
        .stb_i       (bus_stb),
        .adr_i       (bus_adr),
        .dat_o       (bus_rdat),
        .ack_o       (bus_ack),
        .err_o       (bus_err),
        .base_stb_o  (base_stb),
        .base_ack_i  (base_ack),
        .base_dat_i  (base_rdat),
        .ext_stb_o   (ext_stb),
        .ext_ack_i   (ext_ack),
        .ext_dat_i   (ext_rdat),
        .clint_stb_o (clint_stb),
        .clint_ack_i (clint_ack),
        .clint_dat_i (clint_rdat)
    );

    // Base RAM window at 0x8000_0000
    wb_ram #(
        .RAM_WORDS (RAM_WORDS_DEFAULT)
    ) base_ram (
        .sys_clk_i (sys_clk_i),
        .sys_rst_i (sys_rst_i),
        .stb_i     (base_stb),
        .we_i      (bus_we),
        .sel_i     (bus_sel),
        .adr_i     (bus_adr),
        .dat_i     (bus_wdat),
        .dat_o     (base_rdat),
        .ack_o     (base_ack)
    );

    // Ext RAM window at 0x8040_0000
    wb_ram #(
        .RAM_WORDS (RAM_WORDS_DEFAULT)
    ) ext_ram (
        .sys_clk_i (sys_clk_i),
        .sys_rst_i (sys_rst_i),
        .stb_i     (ext_stb),
        .we_i      (bus_we),
        .sel_i     (bus_sel),
        .adr_i     (bus_adr),
        .dat_i     (bus_wdat),
        .dat_o     (ext_rdat),
        .ack_o     (ext_ack)
    );

    clint u_clint (
        .sys_clk_i   (sys_clk_i),
        .sys_rst_i   (sys_rst_i),
        .stb_i       (clint_stb),
        .we_i        (bus_we),
        .sel_i       (bus_sel),
        .adr_i       (bus_adr),
        .dat_i       (bus_wdat),
        .dat_o       (clint_rdat),
        .ack_o       (clint_ack),
        .timer_irq_o (timer_irq_o),
        .mtime_o     (mtime_o)
    );

endmodule

//--- bench/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb;
    import soc_bus_pkg::*;

    // Run length and timeout budget
    localparam int RESET_CYCLES = 8;
    localparam int N_WORDS      = 8;
    localparam int N_ACCESSES   = 62;
    localparam int ACCESS_BOUND = 10;
    localparam int IRQ_WAIT     = 60;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_ACCESSES * ACCESS_BOUND + IRQ_WAIT;

    // CLINT register addresses
    localparam logic [ADDR_W-1:0] CMP_LO_ADR   = CLINT_BASE | {16'h0000, MTIMECMP_LO_OFS};
    localparam logic [ADDR_W-1:0] CMP_HI_ADR   = CLINT_BASE | {16'h0000, MTIMECMP_HI_OFS};
    localparam logic [ADDR_W-1:0] MTIME_LO_ADR = CLINT_BASE | {16'h0000, MTIME_LO_OFS};
    localparam logic [ADDR_W-1:0] MTIME_HI_ADR = CLINT_BASE | {16'h0000, MTIME_HI_OFS};

    logic               sys_clk = 1'b0;
    logic               sys_rst;
    logic               data_cyc;
    logic               data_stb;
    logic               data_we;
    logic [SEL_W-1:0]   data_sel;
    logic [ADDR_W-1:0]  data_adr;
    logic [DATA_W-1:0]  data_wdat;
    logic [DATA_W-1:0]  data_rdat;
    logic               data_ack;
    logic               data_err;
    logic               inst_cyc;
    logic               inst_stb;
    logic               inst_we;
    logic [SEL_W-1:0]   inst_sel;
    logic [ADDR_W-1:0]  inst_adr;
    logic [DATA_W-1:0]  inst_wdat;
    logic [DATA_W-1:0]  inst_rdat;
    logic               inst_ack;
    logic               inst_err;
    logic               timer_irq;
    logic [MTIME_W-1:0] mtime;

    int                 cycle_cnt = 0;
    int                 check_cnt = 0;
    int                 error_cnt = 0;
    logic [15:0]        lfsr_q = 16'd50718;
    // Expected RAM contents with [0] Base RAM and [1] Ext RAM
    logic [DATA_W-1:0]  model_mem [2][N_WORDS];

    soc_bus_top dut (
        .sys_clk_i   (sys_clk),
        .sys_rst_i   (sys_rst),
        .data_cyc_i  (data_cyc),
        .data_stb_i  (data_stb),
        .data_we_i   (data_we),
        .data_sel_i  (data_sel),
        .data_adr_i  (data_adr),
        .data_dat_i  (data_wdat),
        .data_dat_o  (data_rdat),
        .data_ack_o  (data_ack),
        .data_err_o  (data_err),
        .inst_cyc_i  (inst_cyc),
        .inst_stb_i  (inst_stb),
        .inst_we_i   (inst_we),
        .inst_sel_i  (inst_sel),
        .inst_adr_i  (inst_adr),
        .inst_dat_i  (inst_wdat),
        .inst_dat_o  (inst_rdat),
        .inst_ack_o  (inst_ack),
        .inst_err_o  (inst_err),
        .timer_irq_o (timer_irq),
        .mtime_o     (mtime)
    );

    // 20 ns period
    always #10 sys_clk = ~sys_clk;

    // Watchdog
    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, an access never finished", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_random(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    // Bytes with sel set come from new_val
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
            input logic [DATA_W-1:0] new_val, input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < SEL_W; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
            input logic [DATA_W-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("error %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_mtime(input string name, input logic [MTIME_W-1:0] exp,
            input logic [MTIME_W-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // One Wishbone access from either master
    // waits counts the cycles before the ack cycle
    task automatic bus_access(input logic use_inst, input logic we, input logic [SEL_W-1:0] sel,
            input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdat,
            output logic [DATA_W-1:0] rdat, output logic got_ack, output logic got_err,
            output int waits);
        logic done;
        done = 1'b0;
        waits = 0;
        @(posedge sys_clk);
        #1;
        if (use_inst) begin
            inst_cyc = 1'b1;
            inst_stb = 1'b1;
            inst_we = we;
            inst_sel = sel;
            inst_adr = adr;
            inst_wdat = wdat;
        end else begin
            data_cyc = 1'b1;
            data_stb = 1'b1;
            data_we = we;
            data_sel = sel;
            data_adr = adr;
            data_wdat = wdat;
        end
        // Responses sampled mid-cycle
        while (!done) begin
            @(negedge sys_clk);
            got_ack = use_inst ? inst_ack : data_ack;
            got_err = use_inst ? inst_err : data_err;
            rdat = use_inst ? inst_rdat : data_rdat;
            if (got_ack || got_err) begin
                done = 1'b1;
            end else begin
                waits++;
            end
        end
        // Release in the cycle after the response edge
        @(posedge sys_clk);
        #1;
        if (use_inst) begin
            inst_cyc = 1'b0;
            inst_stb = 1'b0;
            inst_we = 1'b0;
        end else begin
            data_cyc = 1'b0;
            data_stb = 1'b0;
            data_we = 1'b0;
        end
    endtask

    // Lone accesses see the bare two-cycle latency
    task automatic write_word(input string name, input logic use_inst,
            input logic [ADDR_W-1:0] adr, input logic [SEL_W-1:0] sel,
            input logic [DATA_W-1:0] wdat);
        logic [DATA_W-1:0] rdat;
        logic              ack;
        logic              err;
        int                waits;
        bus_access(use_inst, 1'b1, sel, adr, wdat, rdat, ack, err, waits);
        check_flag({name, " ack"}, 1'b1, ack);
        check_flag({name, " latency"}, 1'b1, waits == 2);
    endtask

    task automatic read_word(input string name, input logic use_inst,
            input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdat);
        logic ack;
        logic err;
        int   waits;
        bus_access(use_inst, 1'b0, 4'hF, adr, '0, rdat, ack, err, waits);
        check_flag({name, " ack"}, 1'b1, ack);
        check_flag({name, " latency"}, 1'b1, waits == 2);
    endtask

    task automatic reset_state();
        @(negedge sys_clk);
        check_flag("reset data ack", 1'b0, data_ack);
        check_flag("reset data err", 1'b0, data_err);
        check_flag("reset inst ack", 1'b0, inst_ack);
        check_flag("reset inst err", 1'b0, inst_err);
        check_flag("reset timer irq", 1'b0, timer_irq);
    endtask

    // Data master writes and instruction master reads back
    task automatic ram_write_readback();
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] val;
        logic [DATA_W-1:0] rdat;
        logic [31:0]       tmp;
        logic [SEL_W-1:0]  sel;
        for (int k = 0; k < N_WORDS; k++) begin
            for (int w = 0; w < 2; w++) begin
                adr = (w == 0 ? BASERAM_BASE : EXTRAM_BASE) + k * 32;
                val = next_random(32);
                write_word("ram full write", 1'b0, adr, 4'hF, val);
                model_mem[w][k] = val;
                // Odd words get a second partial write
                if (k % 2 == 1) begin
                    tmp = next_random(4);
                    sel = (tmp[3:0] == 4'h0) ? 4'b0110 : tmp[3:0];
                    val = next_random(32);
                    write_word("ram byte write", 1'b0, adr, sel, val);
                    model_mem[w][k] = merge_bytes(model_mem[w][k], val, sel);
                end
            end
        end
        for (int k = 0; k < N_WORDS; k++) begin
            for (int w = 0; w < 2; w++) begin
                adr = (w == 0 ? BASERAM_BASE : EXTRAM_BASE) + k * 32;
                read_word("ram read", 1'b1, adr, rdat);
                check_word("ram read data", model_mem[w][k], rdat);
            end
        end
    endtask

    // Same offset in both windows plus aliasing by RAM depth
    task automatic window_alias();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] ra;
        logic [DATA_W-1:0] rb;
        logic [DATA_W-1:0] rdat;
        a = next_random(32);
        b = next_random(32);
        if (a == b) begin
            b = ~b;
        end
        write_word("base window write", 1'b0, BASERAM_BASE + 32'h400, 4'hF, a);
        write_word("ext window write", 1'b0, EXTRAM_BASE + 32'h400, 4'hF, b);
        read_word("base window read", 1'b1, BASERAM_BASE + 32'h400, ra);
        read_word("ext window read", 1'b1, EXTRAM_BASE + 32'h400, rb);
        check_word("base window data", a, ra);
        check_word("ext window data", b, rb);
        check_flag("windows independent", 1'b1, ra != rb);
        read_word("base alias read", 1'b0, BASERAM_BASE + 32'h400 + RAM_WORDS_DEFAULT * 4, rdat);
        check_word("base alias data", a, rdat);
        read_word("ext alias read", 1'b0, EXTRAM_BASE + 32'h400 + RAM_WORDS_DEFAULT * 4, rdat);
        check_word("ext alias data", b, rdat);
    endtask

    task automatic unmapped_access();
        logic [DATA_W-1:0] rdat;
        logic              ack;
        logic              err;
        int                waits;
        bus_access(1'b0, 1'b0, 4'hF, 32'h1000_0000, '0, rdat, ack, err, waits);
        check_flag("hole read err", 1'b1, err);
        check_flag("hole read ack", 1'b0, ack);
        check_word("hole read data", '0, rdat);
        check_flag("hole read latency", 1'b1, waits == 2);
        bus_access(1'b1, 1'b1, 4'hF, 32'h0000_0000, 32'hDEAD_BEEF, rdat, ack, err, waits);
        check_flag("hole write err", 1'b1, err);
        check_flag("hole write ack", 1'b0, ack);
        check_word("hole write data", '0, rdat);
    endtask

    // Both masters request in the same cycle and the data master finishes first
    task automatic simultaneous_requests();
        logic [DATA_W-1:0] d_rdat;
        logic [DATA_W-1:0] i_rdat;
        logic              d_ack;
        logic              d_err;
        logic              i_ack;
        logic              i_err;
        int                d_waits;
        int                i_waits;
        fork
            bus_access(1'b0, 1'b0, 4'hF, BASERAM_BASE, '0, d_rdat, d_ack, d_err, d_waits);
            bus_access(1'b1, 1'b0, 4'hF, EXTRAM_BASE + 32, '0, i_rdat, i_ack, i_err, i_waits);
        join
        check_flag("arb data ack", 1'b1, d_ack);
        check_flag("arb inst ack", 1'b1, i_ack);
        check_flag("arb data first", 1'b1, d_waits < i_waits);
        check_word("arb data read", model_mem[0][0], d_rdat);
        check_word("arb inst read", model_mem[1][1], i_rdat);
    endtask

    task automatic timer_interrupt();
        logic [DATA_W-1:0]  first;
        logic [DATA_W-1:0]  second;
        logic [DATA_W-1:0]  lo;
        logic [DATA_W-1:0]  hi;
        logic [MTIME_W-1:0] target;
        logic               seen;
        read_word("mtime read one", 1'b0, MTIME_LO_ADR, first);
        read_word("mtime read two", 1'b0, MTIME_LO_ADR, second);
        check_flag("mtime increases", 1'b1, second > first);
        read_word("mtime hi read", 1'b0, MTIME_HI_ADR, hi);
        check_word("mtime hi data", '0, hi);
        read_word("cmp lo read", 1'b0, CMP_LO_ADR, lo);
        read_word("cmp hi read", 1'b0, CMP_HI_ADR, hi);
        check_mtime("mtimecmp after reset", {MTIME_W{1'b1}}, {hi, lo});
        // Low half first keeps the compare value at or above target
        @(negedge sys_clk);
        target = mtime + 64'd40;
        write_word("cmp lo write", 1'b0, CMP_LO_ADR, 4'hF, target[31:0]);
        write_word("cmp hi write", 1'b0, CMP_HI_ADR, 4'hF, target[63:32]);
        @(negedge sys_clk);
        check_flag("irq low after cmp write", 1'b0, timer_irq);
        read_word("cmp lo readback", 1'b1, CMP_LO_ADR, lo);
        read_word("cmp hi readback", 1'b1, CMP_HI_ADR, hi);
        check_mtime("mtimecmp readback", target, {hi, lo});
        seen = 1'b0;
        for (int c = 0; c < IRQ_WAIT && !seen; c++) begin
            @(negedge sys_clk);
            check_flag("irq follows mtime", mtime >= target, timer_irq);
            seen = timer_irq;
        end
        if (!seen) begin
            error_cnt++;
            $display("timer interrupt did not rise within %0d cycles", IRQ_WAIT);
        end
        // All ones parks the compare far ahead
        write_word("cmp lo clear", 1'b0, CMP_LO_ADR, 4'hF, 32'hFFFF_FFFF);
        write_word("cmp hi clear", 1'b0, CMP_HI_ADR, 4'hF, 32'hFFFF_FFFF);
        @(negedge sys_clk);
        check_flag("irq cleared", 1'b0, timer_irq);
    endtask

    initial begin
        sys_rst = 1'b1;
        data_cyc = 1'b0;
        data_stb = 1'b0;
        data_we = 1'b0;
        data_sel = '0;
        data_adr = '0;
        data_wdat = '0;
        inst_cyc = 1'b0;
        inst_stb = 1'b0;
        inst_we = 1'b0;
        inst_sel = '0;
        inst_adr = '0;
        inst_wdat = '0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #1;
        sys_rst = 1'b0;
        reset_state();
        ram_write_readback();
        window_alias();
        unmapped_access();
        simultaneous_requests();
        timer_interrupt();
        $display("checks %0d errors %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/soc_bus_pkg.sv
hdl/wb_arbiter.sv
hdl/wb_decoder.sv
hdl/wb_ram.sv
hdl/clint.sv
hdl/soc_bus_top.sv
bench/soc_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bus testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f files.f --top-module soc_bus_tb -Mdir obj_dir -o soc_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/soc_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
exit 0
